// File: dv/ppu_tb.sv
module ppu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAMES       = 8;
    localparam int LINE_MAX_CYC = 2 * (20 * 3 * 8 + 160 * 2 + 40);  // Reads, stalls, HBLANK
    localparam longint WATCHDOG_NS = longint'(FRAMES) * 154 * LINE_MAX_CYC * 4;

    logic                clk = 1'b0;
    logic                rst = 1'b1;
    ppu_pkg::mmio_req_t  mmio;
    ppu_pkg::byte_t      rdata;
    logic                vram_req;
    ppu_pkg::vram_addr_t vram_addr;
    logic                vram_ack;
    ppu_pkg::byte_t      vram_data;
    logic                pixel_valid;
    ppu_pkg::shade_t     pixel;
    logic                pixel_ready = 1'b0;

    integer         seed = 20;
    int             rnd;
    ppu_pkg::byte_t lcdc_w = '0;
    ppu_pkg::byte_t scy_w = '0;
    ppu_pkg::byte_t scx_w = '0;
    ppu_pkg::byte_t bgp_w = 8'hFC;
    ppu_pkg::byte_t lyc_w = '0;
    logic           check_en = 1'b0;
    int             exp_line = 0;
    int             pix_in_line = 0;
    int             lines_done = 0;
    int             ly_prev = 0;
    logic           stat_pending = 1'b0;
    ppu_pkg::byte_t stat_held;
    logic           frame_wrapped = 1'b0;
    int             coin_hits = 0;
    int             hold_hits = 0;
    logic           hold_prev = 1'b0;
    ppu_pkg::shade_t pixel_prev;
    logic           req_prev = 1'b0;
    logic           ack_prev = 1'b0;
    ppu_pkg::vram_addr_t addr_prev;

    ppu_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .mmio_i        (mmio),
        .mmio_rdata_o  (rdata),
        .vram_req_o    (vram_req),
        .vram_addr_o   (vram_addr),
        .vram_ack_i    (vram_ack),
        .vram_data_i   (vram_data),
        .pixel_valid_o (pixel_valid),
        .pixel_o       (pixel),
        .pixel_ready_i (pixel_ready)
    );

    ppu_vram_model i_vram (
        .clk    (clk),
        .rst    (rst),
        .req_i  (vram_req),
        .addr_i (vram_addr),
        .ack_o  (vram_ack),
        .data_o (vram_data)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp)
        else
            abort_run($sformatf("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp));
    endtask

    // Shade from the pixel rule, using the model memory
    function automatic int expected_shade(input int line, input int pix);
        int row;
        int map_off;
        int tile_addr;
        int k;
        ppu_pkg::byte_t n;
        ppu_pkg::byte_t lo;
        ppu_pkg::byte_t hi;
        logic [1:0]     idx;
        row     = (line + int'(scy_w)) % 256;
        map_off = (lcdc_w[3] ? 'h1C00 : 'h1800) + (row / 8) * 32
                + ((int'(scx_w) / 8 + pix / 8) % 32);
        n = i_vram.read_byte(ppu_pkg::vram_addr_t'(map_off));
        if (lcdc_w[4])
            tile_addr = int'(n) * 16;
        else
            tile_addr = 'h1000 + int'($signed(n)) * 16;
        tile_addr = tile_addr + (row % 8) * 2;
        lo  = i_vram.read_byte(ppu_pkg::vram_addr_t'(tile_addr));
        hi  = i_vram.read_byte(ppu_pkg::vram_addr_t'(tile_addr + 1));
        k   = 7 - pix % 8;
        idx = lcdc_w[0] ? {hi[k], lo[k]} : 2'd0;
        return int'(bgp_w[2 * int'(idx) +: 2]);
    endfunction

    task automatic mmio_write(input ppu_pkg::mmio_addr_t addr, input ppu_pkg::byte_t data);
        @(posedge clk);
        #1;
        mmio.addr  = addr;
        mmio.wdata = data;
        mmio.we    = 1'b1;
        case (addr)
            ppu_pkg::ADDR_LCDC: lcdc_w = data;
            ppu_pkg::ADDR_SCY:  scy_w  = data;
            ppu_pkg::ADDR_SCX:  scx_w  = data;
            ppu_pkg::ADDR_BGP:  bgp_w  = data;
            ppu_pkg::ADDR_LYC:  lyc_w  = data;
            default:
            begin
            end
        endcase
        @(posedge clk);
        #1;
        mmio.we = 1'b0;
    endtask

    // Address driven after the edge, data sampled mid-cycle
    task automatic mmio_read(input ppu_pkg::mmio_addr_t addr, output ppu_pkg::byte_t data,
                             output logic valid);
        @(posedge clk);
        #1;
        mmio.addr = addr;
        mmio.re   = 1'b1;
        @(negedge clk);
        data  = rdata;
        valid = pixel_valid;
    endtask

    task automatic check_reg(input ppu_pkg::mmio_addr_t addr, input int exp);
        ppu_pkg::byte_t v;
        logic           pv;
        mmio_read(addr, v, pv);
        check_value($sformatf("register %h", addr), int'(v), exp);
    endtask

    task automatic poll_ly();
        ppu_pkg::byte_t v;
        logic           pv;
        mmio_read(ppu_pkg::ADDR_LY, v, pv);
        if (int'(v) != ly_prev)
        begin
            check_value("LY", int'(v), (ly_prev == 153) ? 0 : ly_prev + 1);
            if (ly_prev < 144)
            begin
                check_value("pixels left in line", pix_in_line, 0);
                check_value("line index", exp_line, (ly_prev + 1) % 144);
            end
            if (ly_prev == 153)
                frame_wrapped = 1'b1;
        end
        else if (stat_pending)
        begin
            // LY equal on both sides of the STAT read
            check_value("STAT[2]", int'(stat_held[2]), int'(v == lyc_w));
            coin_hits = coin_hits + int'(stat_held[2]);
        end
        stat_pending = 1'b0;
        ly_prev      = int'(v);
    endtask

    task automatic poll_stat();
        ppu_pkg::byte_t s;
        logic           pv;
        mmio_read(ppu_pkg::ADDR_STAT, s, pv);
        if (s[1:0] == 2'd1)
            check_value("pixel_valid_o in VBLANK", int'(pv), 0);
        if (pv)
            check_value("STAT mode", int'(s[1:0]), 3);
        stat_held    = s;
        stat_pending = 1'b1;
    endtask

    task automatic start_frame(input ppu_pkg::byte_t lcdc, input ppu_pkg::byte_t scy,
                               input ppu_pkg::byte_t scx, input ppu_pkg::byte_t bgp,
                               input ppu_pkg::byte_t lyc);
        check_en = 1'b0;
        mmio_write(ppu_pkg::ADDR_LCDC, lcdc & 8'h7F);
        mmio_write(ppu_pkg::ADDR_SCY, scy);
        mmio_write(ppu_pkg::ADDR_SCX, scx);
        mmio_write(ppu_pkg::ADDR_BGP, bgp);
        mmio_write(ppu_pkg::ADDR_LYC, lyc);
        exp_line      = 0;
        pix_in_line   = 0;
        lines_done    = 0;
        ly_prev       = 0;
        stat_pending  = 1'b0;
        frame_wrapped = 1'b0;
        check_en      = 1'b1;
        mmio_write(ppu_pkg::ADDR_LCDC, lcdc);
    endtask

    task automatic run_frame();
        while (!frame_wrapped)
        begin
            poll_ly();
            poll_stat();
        end
    endtask

    // Pixel reference and handshake checks, sampled before each edge takes effect
    always @(posedge clk)
    begin
        if (check_en)
        begin
            if (hold_prev)
            begin
                check_value("pixel_valid_o under stall", int'(pixel_valid), 1);
                check_value("pixel_o under stall", int'(pixel), int'(pixel_prev));
                hold_hits = hold_hits + 1;
            end
            if (pixel_valid && pixel_ready)
            begin
                check_value($sformatf("pixel_o line %0d px %0d", exp_line, pix_in_line),
                            int'(pixel), expected_shade(exp_line, pix_in_line));
                pix_in_line = pix_in_line + 1;
                if (pix_in_line == 160)
                begin
                    pix_in_line = 0;
                    exp_line    = (exp_line + 1) % 144;
                    lines_done  = lines_done + 1;
                end
            end
        end
        if (req_prev && !ack_prev)
            check_value("vram_req_o before ack", int'(vram_req), 1);
        if (!req_prev && vram_req)
            check_value("vram_ack_i when req rises", int'(ack_prev), 0);
        if (req_prev && vram_req)
            check_value("vram_addr_o", int'(vram_addr), int'(addr_prev));
        hold_prev  = check_en && pixel_valid && !pixel_ready;
        pixel_prev = pixel;
        req_prev   = vram_req;
        ack_prev   = vram_ack;
        addr_prev  = vram_addr;
    end

    // Ready low about a quarter of the time
    always @(posedge clk)
    begin
        #1;
        rnd         = $random(seed);
        pixel_ready = (rnd[1:0] != 2'd0);
    end

    initial
    begin
        #(WATCHDOG_NS);
        abort_run("Timeout: the run did not finish in the expected time");
    end

    initial
    begin
        ppu_pkg::byte_t v;
        logic           pv;
        mmio = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        check_reg(ppu_pkg::ADDR_LCDC, 0);
        check_reg(ppu_pkg::ADDR_STAT, 'h04);   // LY equals LYC at reset
        check_reg(ppu_pkg::ADDR_SCY, 0);
        check_reg(ppu_pkg::ADDR_SCX, 0);
        check_reg(ppu_pkg::ADDR_LY, 0);
        check_reg(ppu_pkg::ADDR_LYC, 0);
        check_reg(ppu_pkg::ADDR_BGP, 'hFC);
        mmio_write(ppu_pkg::ADDR_LCDC, 8'h11);
        mmio_write(ppu_pkg::ADDR_SCY, 8'h5A);
        mmio_write(ppu_pkg::ADDR_SCX, 8'hA5);
        mmio_write(ppu_pkg::ADDR_LYC, 8'h33);
        mmio_write(ppu_pkg::ADDR_BGP, 8'h1B);
        mmio_write(ppu_pkg::ADDR_STAT, 8'hFF);
        mmio_write(ppu_pkg::ADDR_LY, 8'h77);
        check_reg(ppu_pkg::ADDR_LCDC, 'h11);
        check_reg(ppu_pkg::ADDR_SCY, 'h5A);
        check_reg(ppu_pkg::ADDR_SCX, 'hA5);
        check_reg(ppu_pkg::ADDR_LYC, 'h33);
        check_reg(ppu_pkg::ADDR_BGP, 'h1B);
        check_reg(ppu_pkg::ADDR_STAT, 'hF8);
        check_reg(ppu_pkg::ADDR_LY, 0);
        check_reg(16'hFF46, 'hFF);
        check_reg(16'hFF4A, 'hFF);

        // Both tile data modes and both maps, then background off
        start_frame(8'h91, 8'h13, 8'h28, 8'hE4, 8'h05);
        run_frame();
        start_frame(8'h81, 8'hF0, 8'hF8, 8'h1B, 8'h40);
        run_frame();
        start_frame(8'h99, 8'h66, 8'h90, 8'h9C, 8'h8F);
        run_frame();
        start_frame(8'h89, 8'hA1, 8'h3B, 8'h27, 8'h00);
        run_frame();
        start_frame(8'h90, 8'h21, 8'h10, 8'hB1, 8'h99);
        run_frame();

        // Display off in the middle of a line
        start_frame(8'h91, 8'h07, 8'h18, 8'hE4, 8'h02);
        while (!(exp_line == 3 && pix_in_line >= 50))
        begin
            poll_ly();
            poll_stat();
        end
        check_en = 1'b0;
        mmio_write(ppu_pkg::ADDR_LCDC, 8'h11);
        repeat (2) @(posedge clk);
        mmio_read(ppu_pkg::ADDR_LY, v, pv);
        check_value("LY after display off", int'(v), 0);
        check_value("pixel_valid_o after display off", int'(pv), 0);
        mmio_read(ppu_pkg::ADDR_STAT, v, pv);
        check_value("STAT mode after display off", int'(v[1:0]), 0);
        start_frame(8'h91, 8'h07, 8'h18, 8'hE4, 8'h02);
        while (lines_done < 2)
        begin
            poll_ly();
            poll_stat();
        end

        if (coin_hits == 0)
            abort_run("The LY=LYC coincidence bit was never seen set");
        else if (hold_hits == 0)
            abort_run("No pixel stall was ever observed");
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: dv/ppu_vram_model.sv
module ppu_vram_model (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_i,
    input  ppu_pkg::vram_addr_t addr_i,
    output logic                ack_o,
    output ppu_pkg::byte_t      data_o
);

    timeunit 1ns;
    timeprecision 100ps;

    ppu_pkg::byte_t mem [8192];
    integer         seed;
    int             rnd;
    logic [1:0]     wait_cnt;   // Cycles left before ack

    initial
    begin
        seed     = 20;
        ack_o    = 1'b0;
        data_o   = '0;
        wait_cnt = 2'd1;
        for (int i = 0; i < 8192; i++)
        begin
            rnd    = $random(seed);
            mem[i] = rnd[7:0];
        end
    end

    // Read port for the reference model
    function automatic ppu_pkg::byte_t read_byte(input ppu_pkg::vram_addr_t a);
        return mem[a];
    endfunction

    // Four-phase responder, acts just after each rising edge
    always @(posedge clk)
    begin
        #1;
        if (rst)
            ack_o = 1'b0;
        else if (ack_o)
        begin
            if (!req_i)
                ack_o = 1'b0;
        end
        else if (req_i)
        begin
            if (wait_cnt == 2'd0)
            begin
                ack_o    = 1'b1;
                data_o   = mem[addr_i];
                rnd      = $random(seed);
                wait_cnt = rnd[1:0];   // 0 to 3 cycles for the next read
            end
            else
                wait_cnt = wait_cnt - 2'd1;
        end
    end

endmodule

// File: ppu.f
src/ppu_pkg.sv
src/ppu_regs.sv
src/ppu_line_ctrl.sv
src/ppu_bg_fetch.sv
src/ppu_pixel_out.sv
src/ppu_top.sv
dv/ppu_vram_model.sv
dv/ppu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the PPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f ppu.f --top-module ppu_tb -o ppu_sim \
    && ./obj_dir/ppu_sim | tee /dev/stderr | grep -q "^Testbench passed$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: src/ppu_bg_fetch.sv
module ppu_bg_fetch (
    input  logic                clk,
    input  logic                rst,
    input  ppu_pkg::lcd_cfg_t   cfg_i,
    input  ppu_pkg::ly_t        ly_i,
    input  logic                line_active_i,
    output logic                vram_req_o,
    output ppu_pkg::vram_addr_t vram_addr_o,
    input  logic                vram_ack_i,
    input  ppu_pkg::byte_t      vram_data_i,
    output ppu_pkg::tile_row_t  row_o,
    output logic                row_valid_o,
    input  logic                row_ready_i
);

    typedef enum logic [2:0] {
        F_IDLE,
        F_MAP,
        F_LO,
        F_HI,
        F_PUSH,
        F_DONE
    } fetch_state_e;

    fetch_state_e        state;
    logic [4:0]          tile_cnt;   // Tile within the line, 0 to 19
    ppu_pkg::byte_t      tile_num;
    ppu_pkg::byte_t      lo_q;
    ppu_pkg::byte_t      row;        // Background row after SCY
    logic [4:0]          map_col;
    ppu_pkg::vram_addr_t map_addr;
    ppu_pkg::vram_addr_t tile_base;
    ppu_pkg::vram_addr_t next_addr;

    // Address for the read the current state is about to issue
    always_comb
    begin
        row     = ly_i + cfg_i.scy;
        map_col = cfg_i.scx[7:3] + tile_cnt;   // Wraps at 32 tiles
        map_addr = (cfg_i.bg_map_sel ? ppu_pkg::MAP1_BASE : ppu_pkg::MAP0_BASE)
                 + ppu_pkg::vram_addr_t'(row[7:3]) * ppu_pkg::MAP_WIDTH
                 + ppu_pkg::vram_addr_t'(map_col);
        if (cfg_i.tile_data_sel)
            tile_base = ppu_pkg::TILE_BASE_UNSIGNED + {1'b0, tile_num, 4'b0000};
        else
            tile_base = ppu_pkg::TILE_BASE_SIGNED + {tile_num[7], tile_num, 4'b0000};
        if (state == F_MAP)
            next_addr = map_addr;
        else
            next_addr = tile_base
                      + ppu_pkg::vram_addr_t'({row[2:0], (state == F_HI)});
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state       <= F_IDLE;
            tile_cnt    <= '0;
            vram_req_o  <= 1'b0;
            vram_addr_o <= '0;
            row_valid_o <= 1'b0;
        end
        else if (!line_active_i)
        begin
            state       <= F_IDLE;
            tile_cnt    <= '0;
            row_valid_o <= 1'b0;
            if (vram_req_o && vram_ack_i)
                vram_req_o <= 1'b0;     // Let an open read complete
        end
        else
        begin
            case (state)
                F_IDLE:
                begin
                    // Drain a read left over from before the line started
                    if (!vram_req_o)
                        state <= F_MAP;
                    else if (vram_ack_i)
                        vram_req_o <= 1'b0;
                end
                F_MAP, F_LO, F_HI:
                begin
                    if (!vram_req_o)
                    begin
                        if (!vram_ack_i)
                        begin
                            vram_req_o  <= 1'b1;
                            vram_addr_o <= next_addr;
                        end
                    end
                    else if (vram_ack_i)
                    begin
                        vram_req_o <= 1'b0;
                        case (state)
                            F_MAP:
                            begin
                                tile_num <= vram_data_i;
                                state    <= F_LO;
                            end
                            F_LO:
                            begin
                                lo_q  <= vram_data_i;
                                state <= F_HI;
                            end
                            default:
                            begin
                                row_o.lo    <= lo_q;
                                row_o.hi    <= vram_data_i;
                                row_valid_o <= 1'b1;
                                state       <= F_PUSH;
                            end
                        endcase
                    end
                end
                F_PUSH:
                begin
                    if (row_ready_i)
                    begin
                        row_valid_o <= 1'b0;
                        if (tile_cnt == ppu_pkg::TILES_PER_LINE - 5'd1)
                            state <= F_DONE;
                        else
                        begin
                            tile_cnt <= tile_cnt + 5'd1;
                            state    <= F_MAP;
                        end
                    end
                end
                default:
                begin
                    // F_DONE holds until line_active falls
                end
            endcase
        end
    end

endmodule

// File: src/ppu_line_ctrl.sv
module ppu_line_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  ppu_pkg::lcd_cfg_t cfg_i,
    input  logic              line_done_i,
    output logic              line_active_o,
    output ppu_pkg::ly_t      ly_o,
    output logic [1:0]        mode_o
);

    ppu_pkg::line_state_e state;
    logic [7:0]           cyc_cnt;   // Cycles spent in HBLANK or VBLANK line

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= ppu_pkg::OFF;
            ly_o    <= '0;
            cyc_cnt <= '0;
        end
        else if (!cfg_i.lcd_on)
        begin
            // Display off wins over everything else
            state   <= ppu_pkg::OFF;
            ly_o    <= '0;
            cyc_cnt <= '0;
        end
        else
        begin
            case (state)
                ppu_pkg::OFF:
                begin
                    state <= ppu_pkg::DRAW;   // Frame restarts at line 0
                end
                ppu_pkg::DRAW:
                begin
                    if (line_done_i)
                    begin
                        state   <= ppu_pkg::HBLANK;
                        cyc_cnt <= '0;
                    end
                end
                ppu_pkg::HBLANK:
                begin
                    cyc_cnt <= cyc_cnt + 8'd1;
                    if (cyc_cnt == ppu_pkg::HBLANK_CYCLES - 8'd1)
                    begin
                        cyc_cnt <= '0;
                        ly_o    <= ly_o + 8'd1;
                        // Last visible line goes into vertical blank
                        if (ly_o == ppu_pkg::VISIBLE_LINES - 8'd1)
                            state <= ppu_pkg::VBLANK;
                        else
                            state <= ppu_pkg::DRAW;
                    end
                end
                default:
                begin
                    cyc_cnt <= cyc_cnt + 8'd1;
                    if (cyc_cnt == ppu_pkg::VBLANK_LINE_CYCLES - 8'd1)
                    begin
                        cyc_cnt <= '0;
                        if (ly_o == ppu_pkg::LAST_LINE)
                        begin
                            ly_o  <= '0;
                            state <= ppu_pkg::DRAW;
                        end
                        else
                            ly_o <= ly_o + 8'd1;
                    end
                end
            endcase
        end
    end

    assign line_active_o = (state == ppu_pkg::DRAW);

    always_comb
    begin
        case (state)
            ppu_pkg::DRAW:   mode_o = 2'd3;
            ppu_pkg::VBLANK: mode_o = 2'd1;
            default:         mode_o = 2'd0;   // HBLANK and OFF
        endcase
    end

endmodule

// File: src/ppu_pixel_out.sv
module ppu_pixel_out (
    input  logic               clk,
    input  logic               rst,
    input  ppu_pkg::lcd_cfg_t  cfg_i,
    input  logic               line_active_i,
    input  ppu_pkg::tile_row_t row_i,
    input  logic               row_valid_i,
    output logic               row_ready_o,
    output logic               pixel_valid_o,
    output ppu_pkg::shade_t    pixel_o,
    input  logic               pixel_ready_i,
    output logic               line_done_o
);

    ppu_pkg::tile_row_t   buf_q;     // One-entry row buffer
    logic                 buf_valid;
    ppu_pkg::tile_row_t   sh_q;      // Current pixel is bit 7 of each plane
    logic [3:0]           sh_cnt;    // Pixels left in the shifter
    logic [7:0]           pix_cnt;
    logic                 accept;
    logic                 load;
    ppu_pkg::color_idx_t  idx;

    assign row_ready_o   = !buf_valid;
    assign pixel_valid_o = line_active_i && (sh_cnt != 4'd0);
    assign accept        = pixel_valid_o && pixel_ready_i;
    assign load          = buf_valid && ((sh_cnt == 4'd0) || (accept && sh_cnt == 4'd1));
    assign line_done_o   = accept && (pix_cnt == ppu_pkg::PIXELS_PER_LINE - 8'd1);

    // BG disable forces color 0 before the palette
    assign idx     = cfg_i.bg_on ? {sh_q.hi[7], sh_q.lo[7]} : 2'd0;
    assign pixel_o = ppu_pkg::shade_t'(cfg_i.bgp >> {idx, 1'b0});

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            buf_valid <= 1'b0;
            sh_cnt    <= '0;
            pix_cnt   <= '0;
        end
        else if (!line_active_i)
        begin
            buf_valid <= 1'b0;
            sh_cnt    <= '0;
            pix_cnt   <= '0;
        end
        else
        begin
            if (row_valid_i && row_ready_o)
            begin
                buf_q     <= row_i;
                buf_valid <= 1'b1;
            end
            if (load)
            begin
                sh_q      <= buf_q;
                sh_cnt    <= 4'd8;
                buf_valid <= 1'b0;
            end
            else if (accept)
            begin
                sh_q.hi <= {sh_q.hi[6:0], 1'b0};
                sh_q.lo <= {sh_q.lo[6:0], 1'b0};
                sh_cnt  <= sh_cnt - 4'd1;
            end
            if (accept)
                pix_cnt <= pix_cnt + 8'd1;
        end
    end

endmodule

// File: src/ppu_pkg.sv
package ppu_pkg;

    // Plain vector types
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] mmio_addr_t;
    typedef logic [12:0] vram_addr_t;   // Offset from 0x8000
    typedef logic [7:0]  ly_t;
    typedef logic [1:0]  shade_t;
    typedef logic [1:0]  color_idx_t;

    // One 8-pixel row of a tile, two bitplanes
    typedef struct packed {
        byte_t hi;
        byte_t lo;
    } tile_row_t;

    typedef struct packed {
        mmio_addr_t addr;
        byte_t      wdata;
        logic       we;
        logic       re;
    } mmio_req_t;

    // Register fields used by the datapath
    typedef struct packed {
        logic  lcd_on;          // LCDC bit 7
        logic  tile_data_sel;   // LCDC bit 4, 1 selects the unsigned tile base
        logic  bg_map_sel;      // LCDC bit 3
        logic  bg_on;           // LCDC bit 0
        byte_t scy;
        byte_t scx;
        byte_t bgp;
    } lcd_cfg_t;

    typedef enum logic [1:0] {
        OFF,
        DRAW,
        HBLANK,
        VBLANK
    } line_state_e;

    localparam mmio_addr_t ADDR_LCDC = 16'hFF40;
    localparam mmio_addr_t ADDR_STAT = 16'hFF41;
    localparam mmio_addr_t ADDR_SCY  = 16'hFF42;
    localparam mmio_addr_t ADDR_SCX  = 16'hFF43;
    localparam mmio_addr_t ADDR_LY   = 16'hFF44;
    localparam mmio_addr_t ADDR_LYC  = 16'hFF45;
    localparam mmio_addr_t ADDR_BGP  = 16'hFF47;

    localparam vram_addr_t MAP0_BASE          = 13'h1800;
    localparam vram_addr_t MAP1_BASE          = 13'h1C00;
    localparam vram_addr_t TILE_BASE_UNSIGNED = 13'h0000;
    localparam vram_addr_t TILE_BASE_SIGNED   = 13'h1000;
    localparam vram_addr_t MAP_WIDTH          = 13'd32;     // Tiles per map row

    localparam logic [4:0] TILES_PER_LINE     = 5'd20;
    localparam logic [7:0] PIXELS_PER_LINE    = 8'd160;
    localparam ly_t        VISIBLE_LINES      = 8'd144;
    localparam ly_t        LAST_LINE          = 8'd153;
    localparam logic [7:0] HBLANK_CYCLES      = 8'd40;
    localparam logic [7:0] VBLANK_LINE_CYCLES = 8'd200;

    localparam byte_t BGP_RESET     = 8'hFC;
    localparam byte_t UNMAPPED_DATA = 8'hFF;

endpackage

// File: src/ppu_regs.sv
module ppu_regs (
    input  logic               clk,
    input  logic               rst,
    input  ppu_pkg::mmio_req_t mmio_i,
    output ppu_pkg::byte_t     mmio_rdata_o,
    input  ppu_pkg::ly_t       ly_i,
    input  logic [1:0]         mode_i,
    output ppu_pkg::lcd_cfg_t  cfg_o
);

    ppu_pkg::byte_t lcdc;
    ppu_pkg::byte_t scy;
    ppu_pkg::byte_t scx;
    ppu_pkg::byte_t lyc;
    ppu_pkg::byte_t bgp;
    logic [4:0]     stat_hi;    // Writable STAT bits 7:3
    logic           coincide;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            lcdc    <= '0;
            stat_hi <= '0;
            scy     <= '0;
            scx     <= '0;
            lyc     <= '0;
            bgp     <= ppu_pkg::BGP_RESET;
        end
        else if (mmio_i.we)
        begin
            // LY is read-only, writes to it fall through
            case (mmio_i.addr)
                ppu_pkg::ADDR_LCDC: lcdc    <= mmio_i.wdata;
                ppu_pkg::ADDR_STAT: stat_hi <= mmio_i.wdata[7:3];
                ppu_pkg::ADDR_SCY:  scy     <= mmio_i.wdata;
                ppu_pkg::ADDR_SCX:  scx     <= mmio_i.wdata;
                ppu_pkg::ADDR_LYC:  lyc     <= mmio_i.wdata;
                ppu_pkg::ADDR_BGP:  bgp     <= mmio_i.wdata;
                default:
                begin
                end
            endcase
        end
    end

    assign coincide = (ly_i == lyc);

    // Combinational read path
    always_comb
    begin
        case (mmio_i.addr)
            ppu_pkg::ADDR_LCDC: mmio_rdata_o = lcdc;
            ppu_pkg::ADDR_STAT: mmio_rdata_o = {stat_hi, coincide, mode_i};
            ppu_pkg::ADDR_SCY:  mmio_rdata_o = scy;
            ppu_pkg::ADDR_SCX:  mmio_rdata_o = scx;
            ppu_pkg::ADDR_LY:   mmio_rdata_o = ly_i;
            ppu_pkg::ADDR_LYC:  mmio_rdata_o = lyc;
            ppu_pkg::ADDR_BGP:  mmio_rdata_o = bgp;
            default:            mmio_rdata_o = ppu_pkg::UNMAPPED_DATA;
        endcase
    end

    always_comb
    begin
        cfg_o.lcd_on        = lcdc[7];
        cfg_o.tile_data_sel = lcdc[4];
        cfg_o.bg_map_sel    = lcdc[3];
        cfg_o.bg_on         = lcdc[0];
        cfg_o.scy           = scy;
        cfg_o.scx           = scx;
        cfg_o.bgp           = bgp;
    end

endmodule

// File: src/ppu_top.sv
module ppu_top (
    input  logic                clk,
    input  logic                rst,
    input  ppu_pkg::mmio_req_t  mmio_i,
    output ppu_pkg::byte_t      mmio_rdata_o,
    output logic                vram_req_o,
    output ppu_pkg::vram_addr_t vram_addr_o,
    input  logic                vram_ack_i,
    input  ppu_pkg::byte_t      vram_data_i,
    output logic                pixel_valid_o,
    output ppu_pkg::shade_t     pixel_o,
    input  logic                pixel_ready_i
);

    ppu_pkg::lcd_cfg_t  cfg;
    ppu_pkg::ly_t       ly;
    logic [1:0]         mode;
    logic               line_active;
    logic               line_done;
    ppu_pkg::tile_row_t row;
    logic               row_valid;
    logic               row_ready;

    ppu_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .mmio_i       (mmio_i),
        .mmio_rdata_o (mmio_rdata_o),
        .ly_i         (ly),
        .mode_i       (mode),
        .cfg_o        (cfg)
    );

    ppu_line_ctrl u_line_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cfg_i         (cfg),
        .line_done_i   (line_done),
        .line_active_o (line_active),
        .ly_o          (ly),
        .mode_o        (mode)
    );

    ppu_bg_fetch u_bg_fetch (
        .clk           (clk),
        .rst           (rst),
        .cfg_i         (cfg),
        .ly_i          (ly),
        .line_active_i (line_active),
        .vram_req_o    (vram_req_o),
        .vram_addr_o   (vram_addr_o),
        .vram_ack_i    (vram_ack_i),
        .vram_data_i   (vram_data_i),
        .row_o         (row),
        .row_valid_o   (row_valid),
        .row_ready_i   (row_ready)
    );

    ppu_pixel_out u_pixel_out (
        .clk           (clk),
        .rst           (rst),
        .cfg_i         (cfg),
        .line_active_i (line_active),
        .row_i         (row),
        .row_valid_i   (row_valid),
        .row_ready_o   (row_ready),
        .pixel_valid_o (pixel_valid_o),
        .pixel_o       (pixel_o),
        .pixel_ready_i (pixel_ready_i),
        .line_done_o   (line_done)
    );

endmodule
